/* dv/tb_clock.sv */
`timescale 1ns/1ps

// free running clock and the power-on reset of the testbench
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam time HALF_PERIOD = 50ns;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* dv/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int RESET_CYCLES = 5;
    // bus accesses of all tests together including the delayed reruns
    localparam int TOTAL_ACCESSES = 54;
    // a zero delay access takes about ten cycles and a slow ack adds up to four
    localparam int CYCLES_PER_ACCESS = 14;
    localparam int CYCLE_LIMIT = 20 * TOTAL_ACCESSES * CYCLES_PER_ACCESS;
    localparam int DELAY_COUNT = 64;

    logic                clk;
    logic                por_rst;
    logic                test_rst = 1'b0;
    logic                rst;
    logic                mem_req;
    cpu_bus_pkg::addr_t  mem_addr;
    cpu_bus_pkg::data_t  mem_wdata;
    logic                mem_we;
    logic                mem_ack = 1'b0;
    cpu_bus_pkg::data_t  mem_rdata = 8'h00;

    logic [7:0]   mem [256];
    logic         random_ack = 1'b0;
    logic         waiting = 1'b0;
    int unsigned  delay_left = 0;
    int unsigned  ack_delay [DELAY_COUNT];
    int unsigned  delay_index = 0;
    int           write_count = 0;
    logic         idle_seen = 1'b0;
    logic [7:0]   last_fetch = 8'hff;
    logic [7:0]   acc_addr [$];
    logic         acc_we [$];
    int           cycle_count = 0;
    int           errors = 0;
    int           test_errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           checks = 0;

    assign rst = por_rst | test_rst;

    tb_clock i_clock (
        .clk (clk),
        .rst (por_rst)
    );

    cpu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    // memory answers a request after zero or more extra cycles and drops ack once req falls
    always @(posedge clk) begin : memory_model
        int unsigned delay;
        if (rst || !mem_req) begin
            mem_ack <= 1'b0;
            waiting <= 1'b0;
        end else if (!mem_ack) begin
            if (!waiting) begin
                if (random_ack) begin
                    delay       = ack_delay[delay_index % DELAY_COUNT];
                    delay_index <= delay_index + 1;
                end else begin
                    delay = 0;
                end
            end else begin
                delay = delay_left;
            end
            if (delay == 0) begin
                mem_ack <= 1'b1;
                if (mem_we) begin
                    mem[mem_addr] <= mem_wdata;
                    write_count   <= write_count + 1;
                end else begin
                    mem_rdata <= mem[mem_addr];
                    // code sits below the data region so two fetches in a row at one
                    // address can only come from a jump to itself
                    if (mem_addr < 8'he0) begin
                        if (mem_addr == last_fetch) begin
                            idle_seen <= 1'b1;
                        end
                        last_fetch <= mem_addr;
                    end
                end
                acc_addr.push_back(mem_addr);
                acc_we.push_back(mem_we);
            end else begin
                waiting    <= 1'b1;
                delay_left <= delay - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] encode(cpu_isa_pkg::inst_type_e itype, logic sel,
                                          logic [4:0] operand);
        return {itype, sel, operand};
    endfunction

    function automatic logic [7:0] jump_to(logic [5:0] target);
        return {cpu_isa_pkg::INST_JUMP, target};
    endfunction

    task automatic compare_value(input string what, input logic [7:0] got,
                                 input logic [7:0] expected);
        checks++;
        if (got !== expected) begin
            $display("** Error at %0t: %s is 0x%02h, expected 0x%02h",
                     $time, what, got, expected);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s", name, (test_errors == 0) ? "ok" : "mismatch");
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic fill_memory();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'ha5;
        end
    endtask

    task automatic begin_reset();
        @(posedge clk);
        test_rst <= 1'b1;
        repeat (2) @(posedge clk);
        write_count = 0;
        idle_seen   = 1'b0;
        last_fetch  = 8'hff;
        acc_addr.delete();
        acc_we.delete();
    endtask

    task automatic end_reset();
        repeat (RESET_CYCLES - 2) @(posedge clk);
        test_rst <= 1'b0;
    endtask

    task automatic run_until_idle(input int writes);
        @(negedge clk);
        while (!(idle_seen && write_count >= writes)) begin
            @(negedge clk);
        end
    endtask

    task automatic copy_test(output logic [7:0] result);
        logic [7:0] value;
        value = 8'h3c;
        begin_reset();
        fill_memory();
        mem[8'h00] = encode(cpu_isa_pkg::INST_LOAD, 1'b1, 5'd0);
        mem[8'h01] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd1);
        mem[8'h02] = jump_to(6'd2);
        mem[8'he0] = value;
        mem[8'he1] = 8'h00;
        end_reset();
        run_until_idle(1);
        compare_value("copy target 0xe1", mem[8'he1], value);
        compare_value("copy source 0xe0", mem[8'he0], value);
        result = mem[8'he1];
    endtask

    task automatic add_wrap_test(output logic [7:0] result);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] expected;
        x = 8'hc8;
        y = 8'h50;
        expected = 8'((int'(x) + int'(y)) % 256);
        begin_reset();
        fill_memory();
        mem[8'h00] = encode(cpu_isa_pkg::INST_LOAD, 1'b1, 5'd0);
        mem[8'h01] = encode(cpu_isa_pkg::INST_LOAD, 1'b0, 5'd1);
        mem[8'h02] = encode(cpu_isa_pkg::INST_ADD, 1'b1, 5'd0);
        mem[8'h03] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd2);
        mem[8'h04] = jump_to(6'd4);
        mem[8'he0] = x;
        mem[8'he1] = y;
        mem[8'he2] = 8'h00;
        end_reset();
        run_until_idle(1);
        compare_value("sum at 0xe2", mem[8'he2], expected);
        result = mem[8'he2];
    endtask

    task automatic jump_skip_test();
        logic [7:0] value;
        value = 8'h77;
        begin_reset();
        fill_memory();
        mem[8'h00] = encode(cpu_isa_pkg::INST_LOAD, 1'b1, 5'd0);
        mem[8'h01] = jump_to(6'd3);
        mem[8'h02] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd2);
        mem[8'h03] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd3);
        mem[8'h04] = jump_to(6'd4);
        mem[8'he0] = value;
        mem[8'he2] = 8'h5a;
        mem[8'he3] = 8'h00;
        end_reset();
        run_until_idle(1);
        compare_value("skipped store 0xe2", mem[8'he2], 8'h5a);
        compare_value("store after target 0xe3", mem[8'he3], value);
        compare_value("write count", 8'(write_count), 8'd1);
    endtask

    task automatic idle_loop_test();
        begin_reset();
        fill_memory();
        mem[8'h00] = jump_to(6'd5);
        mem[8'h05] = jump_to(6'd5);
        end_reset();
        @(negedge clk);
        while (acc_addr.size() < 5) begin
            @(negedge clk);
        end
        compare_value("first fetch address", acc_addr[0], 8'h00);
        for (int i = 0; i < 5; i++) begin
            if (i > 0) begin
                compare_value("idle fetch address", acc_addr[i], 8'h05);
            end
            compare_value("idle fetch we", acc_we[i], 8'h00);
        end
        compare_value("write count", 8'(write_count), 8'd0);
    endtask

    // the same programs again while the memory answers late
    task automatic back_pressure_test(input logic [7:0] copy_ref, input logic [7:0] add_ref);
        logic [7:0] result;
        random_ack = 1'b1;
        copy_test(result);
        compare_value("delayed copy vs zero delay", result, copy_ref);
        add_wrap_test(result);
        compare_value("delayed sum vs zero delay", result, add_ref);
        random_ack = 1'b0;
    endtask

    task automatic reset_test();
        logic [7:0] value;
        value = 8'h6e;
        begin_reset();
        fill_memory();
        mem[8'h00] = encode(cpu_isa_pkg::INST_LOAD, 1'b1, 5'd0);
        mem[8'h01] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd1);
        mem[8'h02] = encode(cpu_isa_pkg::INST_STORE, 1'b1, 5'd2);
        mem[8'h03] = jump_to(6'd3);
        mem[8'he0] = value;
        mem[8'he1] = 8'h00;
        mem[8'he2] = 8'h00;
        end_reset();
        @(negedge clk);
        while (write_count < 1) begin
            @(negedge clk);
        end
        begin_reset();
        // the rerun has to write 0xe1 again
        mem[8'he1] = 8'h00;
        @(negedge clk);
        compare_value("mem_req in reset", mem_req, 8'h00);
        compare_value("mem_we in reset", mem_we, 8'h00);
        end_reset();
        repeat (2) @(negedge clk);
        compare_value("mem_req one cycle after reset", mem_req, 8'h00);
        @(negedge clk);
        compare_value("mem_req two cycles after reset", mem_req, 8'h01);
        while (acc_addr.size() < 1) begin
            @(negedge clk);
        end
        compare_value("first fetch after reset", acc_addr[0], 8'h00);
        compare_value("first fetch we", acc_we[0], 8'h00);
        run_until_idle(2);
        compare_value("rerun store 0xe1", mem[8'he1], value);
        compare_value("rerun store 0xe2", mem[8'he2], value);
    endtask

    initial begin
        logic [7:0] copy_ref;
        logic [7:0] add_ref;
        void'($urandom(32'h5b57_3b5e));
        for (int i = 0; i < DELAY_COUNT; i++) begin
            ack_delay[i] = $urandom % 5;
        end
        copy_test(copy_ref);
        finish_test("load/store copy");
        add_wrap_test(add_ref);
        finish_test("add wrap");
        jump_skip_test();
        finish_test("jump skip");
        idle_loop_test();
        finish_test("idle loop");
        back_pressure_test(copy_ref, add_ref);
        finish_test("back-pressure");
        reset_test();
        finish_test("reset");
        $display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // bus clients in arbitration order, fetch first
    typedef enum logic {
        CLIENT_FETCH = 1'b0,
        CLIENT_DATA  = 1'b1
    } client_e;

endpackage

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                clk,
    input  logic                rst,
    input  cpu_isa_pkg::inst_t  inst,
    input  logic                inst_valid,
    output logic                fetch_start,
    output cpu_bus_pkg::addr_t  pc,
    mem_req_if.client           bus
);

    typedef enum logic [1:0] {
        C_START,
        C_DECODE,
        C_REQ,
        C_ACK_LO
    } core_state_e;

    core_state_e         state;
    cpu_bus_pkg::addr_t  pc_q;
    cpu_bus_pkg::data_t  a;
    cpu_bus_pkg::data_t  b;
    cpu_bus_pkg::data_t  sum;
    logic                req_q;
    logic                we_q;
    cpu_bus_pkg::addr_t  addr_q;
    cpu_bus_pkg::data_t  wdata_q;
    cpu_bus_pkg::addr_t  data_addr;
    logic [cpu_isa_pkg::TARGET_W-1:0] target;

    assign sum       = a + b;
    assign target    = {inst.sel, inst.operand};
    assign data_addr = {cpu_isa_pkg::DATA_BASE, inst.operand};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= C_START;
            pc_q  <= '0;
            a     <= '0;
            b     <= '0;
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            case (state)
                C_START: begin
                    state <= C_DECODE;
                end
                C_DECODE: begin
                    if (inst_valid) begin
                        case (inst.itype)
                            cpu_isa_pkg::INST_JUMP: begin
                                pc_q  <= cpu_bus_pkg::addr_t'(target);
                                state <= C_START;
                            end
                            cpu_isa_pkg::INST_ADD: begin
                                if (inst.sel) begin
                                    a <= sum;
                                end else begin
                                    b <= sum;
                                end
                                pc_q  <= pc_q + 1'b1;
                                state <= C_START;
                            end
                            default: begin
                                // load and store both go out as one data access
                                req_q <= 1'b1;
                                we_q  <= (inst.itype == cpu_isa_pkg::INST_STORE);
                                state <= C_REQ;
                            end
                        endcase
                    end
                end
                C_REQ: begin
                    if (bus.ack) begin
                        req_q <= 1'b0;
                        if (!we_q && inst.sel) begin
                            a <= bus.rdata;
                        end else if (!we_q) begin
                            b <= bus.rdata;
                        end
                        state <= C_ACK_LO;
                    end
                end
                C_ACK_LO: begin
                    if (!bus.ack) begin
                        we_q  <= 1'b0;
                        pc_q  <= pc_q + 1'b1;
                        state <= C_START;
                    end
                end
                default: state <= C_START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_DECODE && inst_valid) begin
            addr_q  <= data_addr;
            wdata_q <= inst.sel ? a : b;
        end
    end

    assign fetch_start = (state == C_START);
    assign pc          = pc_q;
    assign bus.req     = req_q;
    assign bus.we      = we_q;
    assign bus.addr    = addr_q;
    assign bus.wdata   = wdata_q;

    // a new fetch only starts after the data handshake has fully closed at the port
    a_fetch_after_data: assert property (@(posedge clk) disable iff (rst)
        fetch_start |-> !bus.req && !bus.ack);

endmodule

/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    // one instruction byte is type, select and operand, from msb down
    localparam int TYPE_W = 2;
    localparam int OPERAND_W = 5;

    // a jump target is the select bit on top of the operand
    localparam int TARGET_W = OPERAND_W + 1;

    // data accesses land in the top 32 bytes of the address space
    localparam int DATA_BASE_W = 3;
    localparam logic [DATA_BASE_W-1:0] DATA_BASE = 3'b111;

    typedef enum logic [TYPE_W-1:0] {
        INST_JUMP  = 2'b00,
        INST_LOAD  = 2'b01,
        INST_STORE = 2'b10,
        INST_ADD   = 2'b11
    } inst_type_e;

    // sel picks register a when set and b when clear
    typedef struct packed {
        inst_type_e             itype;
        logic                   sel;
        logic [OPERAND_W-1:0]   operand;
    } inst_t;

endpackage

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                clk,
    input  logic                rst,
    output logic                mem_req,
    output cpu_bus_pkg::addr_t  mem_addr,
    output cpu_bus_pkg::data_t  mem_wdata,
    output logic                mem_we,
    input  logic                mem_ack,
    input  cpu_bus_pkg::data_t  mem_rdata
);

    logic                fetch_start;
    logic                inst_valid;
    cpu_bus_pkg::addr_t  pc;
    cpu_isa_pkg::inst_t  inst;

    mem_req_if fetch_bus ();
    mem_req_if data_bus ();

    fetch_unit i_fetch (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .pc          (pc),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .bus         (fetch_bus)
    );

    cpu_core i_core (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .fetch_start (fetch_start),
        .pc          (pc),
        .bus         (data_bus)
    );

    // only one of the two clients is ever pending, the port still arbitrates
    mem_port i_port (
        .clk         (clk),
        .rst         (rst),
        .fetch_bus   (fetch_bus),
        .data_bus    (data_bus),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_ack     (mem_ack),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_start,
    input  cpu_bus_pkg::addr_t  pc,
    output cpu_isa_pkg::inst_t  inst,
    output logic                inst_valid,
    mem_req_if.client           bus
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_ACK_LO
    } fetch_state_e;

    fetch_state_e        state;
    logic                req_q;
    logic                inst_valid_q;
    cpu_bus_pkg::addr_t  addr_q;
    cpu_isa_pkg::inst_t  inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= F_IDLE;
            req_q        <= 1'b0;
            inst_valid_q <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (fetch_start) begin
                        req_q        <= 1'b1;
                        inst_valid_q <= 1'b0;
                        state        <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (bus.ack) begin
                        req_q <= 1'b0;
                        state <= F_ACK_LO;
                    end
                end
                F_ACK_LO: begin
                    // the byte is only handed over once the handshake is closed
                    if (!bus.ack) begin
                        inst_valid_q <= 1'b1;
                        state        <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && fetch_start) begin
            addr_q <= pc;
        end
        if (state == F_REQ && bus.ack) begin
            inst_q <= cpu_isa_pkg::inst_t'(bus.rdata);
        end
    end

    assign bus.req    = req_q;
    assign bus.addr   = addr_q;
    assign bus.we     = 1'b0;
    assign bus.wdata  = '0;
    assign inst       = inst_q;
    assign inst_valid = inst_valid_q;

    // the read request is only withdrawn against a standing ack from the port
    a_req_until_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(bus.req) |-> bus.ack);

endmodule

/* src/mem_port.sv */
`timescale 1ns/1ps

module mem_port (
    input  logic                clk,
    input  logic                rst,
    mem_req_if.server           fetch_bus,
    mem_req_if.server           data_bus,
    output logic                mem_req,
    output cpu_bus_pkg::addr_t  mem_addr,
    output cpu_bus_pkg::data_t  mem_wdata,
    output logic                mem_we,
    input  logic                mem_ack,
    input  cpu_bus_pkg::data_t  mem_rdata
);

    logic                  busy;
    cpu_bus_pkg::client_e  grant;
    logic                  ack_q;
    cpu_bus_pkg::data_t    rdata_q;
    logic                  any_req;
    logic                  grant_req;

    assign any_req   = fetch_bus.req || data_bus.req;
    assign grant_req = (grant == cpu_bus_pkg::CLIENT_FETCH) ? fetch_bus.req : data_bus.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            grant   <= cpu_bus_pkg::CLIENT_FETCH;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= mem_ack;
            if (!busy) begin
                if (any_req) begin
                    busy    <= 1'b1;
                    mem_req <= 1'b1;
                    // fetch has priority
                    if (fetch_bus.req) begin
                        grant  <= cpu_bus_pkg::CLIENT_FETCH;
                        mem_we <= 1'b0;
                    end else begin
                        grant  <= cpu_bus_pkg::CLIENT_DATA;
                        mem_we <= data_bus.we;
                    end
                end
            end else begin
                mem_req <= grant_req;
                // the grant is freed only once the external ack is seen low
                if (!mem_req && !ack_q && !grant_req) begin
                    busy   <= 1'b0;
                    mem_we <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= mem_rdata;
        if (!busy && any_req) begin
            mem_addr  <= fetch_bus.req ? fetch_bus.addr : data_bus.addr;
            mem_wdata <= fetch_bus.req ? fetch_bus.wdata : data_bus.wdata;
        end
    end

    assign fetch_bus.ack   = busy && (grant == cpu_bus_pkg::CLIENT_FETCH) && ack_q;
    assign data_bus.ack    = busy && (grant == cpu_bus_pkg::CLIENT_DATA) && ack_q;
    assign fetch_bus.rdata = (grant == cpu_bus_pkg::CLIENT_FETCH) ? rdata_q : '0;
    assign data_bus.rdata  = (grant == cpu_bus_pkg::CLIENT_DATA) ? rdata_q : '0;

    // the external memory must answer before the request is withdrawn
    a_mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req);

    a_fetch_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        $rose(fetch_bus.ack) |-> fetch_bus.req);

    a_data_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        $rose(data_bus.ack) |-> data_bus.req);

endmodule

/* src/mem_req_if.sv */
`timescale 1ns/1ps

// four-phase request/acknowledge link between a bus client and the memory port
interface mem_req_if;

    logic               req;
    logic               ack;
    logic               we;
    cpu_bus_pkg::addr_t addr;
    cpu_bus_pkg::data_t wdata;
    cpu_bus_pkg::data_t rdata;

    modport client (
        output req,
        output addr,
        output wdata,
        output we,
        input  ack,
        input  rdata
    );

    modport server (
        input  req,
        input  addr,
        input  wdata,
        input  we,
        output ack,
        output rdata
    );

endinterface

/* vlog.f */
src/cpu_isa_pkg.sv
src/cpu_bus_pkg.sv
src/mem_req_if.sv
src/fetch_unit.sv
src/cpu_core.sv
src/mem_port.sv
src/cpu_top.sv
dv/tb_clock.sv
dv/tb_cpu.sv
